/* vlog.f */
+incdir+hw
hw/soc_pkg.sv
hw/bus_req_if.sv
hw/pipe_reg.sv
hw/addr_decode_stage.sv
hw/sram_word.sv
hw/gpio_regs.sv
hw/slave_access_stage.sv
hw/response_stage.sv
hw/soc_fabric_top.sv
test/tb_soc_fabric.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_pkg.sv
      - hw/bus_req_if.sv
      - hw/pipe_reg.sv
      - hw/addr_decode_stage.sv
      - hw/sram_word.sv
      - hw/gpio_regs.sv
      - hw/slave_access_stage.sv
      - hw/response_stage.sv
      - hw/soc_fabric_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_soc_fabric.sv

/* test/tb_soc_fabric.sv */
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_fabric;
  import soc_pkg::*;

  localparam int MAX_ENTRIES = 40;
  localparam int MODEL_WORDS = 256;
  localparam int RESET_CYCLES = 8;

  typedef struct packed {
    logic   write;
    haddr_t addr;
    hdata_t data;
    hdata_t exp_rdata;
    logic   exp_err;
  } entry_t;

  logic               clk;
  logic               reset_n;
  haddr_t             haddr_i;
  htrans_e            htrans_i;
  logic               hwrite_i;
  hdata_t             hwdata_i;
  hdata_t             hrdata_o;
  logic               hready_o;
  logic               hresp_o;
  logic [`GPIO_W-1:0] gpio_i;
  logic [`GPIO_W-1:0] gpio_o;

  entry_t             stim [MAX_ENTRIES];
  int                 num_entries;
  logic               stim_ready;
  logic [31:0]        lfsr_state;
  hdata_t             iram_model [MODEL_WORDS];
  hdata_t             dram_model [MODEL_WORDS];
  logic [`GPIO_W-1:0] gpio_model;
  logic [`GPIO_W-1:0] gpio_in_value;

  soc_fabric_top soc_fabric_top_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic hdata_t random_bits(input int n);
    hdata_t w;
    w = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[`SOC_DATA_W-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_data(input hdata_t got, input hdata_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: hrdata %h, expected %h", what, got, exp));
  endtask

  task automatic check_resp(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: hresp %b, expected %b", what, got, exp));
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: hready %b, expected %b", what, got, exp));
  endtask

  task automatic check_gpio(input logic [`GPIO_W-1:0] got, input logic [`GPIO_W-1:0] exp,
                            input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: gpio_o %h, expected %h", what, got, exp));
  endtask

  // expected values follow the address map and a word model of each target
  task automatic add_entry(input logic write, input haddr_t addr);
    entry_t e;
    int     idx;
    logic   in_iram;
    logic   in_dram;
    logic   in_gpio;
    in_iram     = (addr >> 12) == (`IRAM_BASE >> 12);
    in_dram     = (addr >> 12) == (`DRAM_BASE >> 12);
    in_gpio     = (addr >> 12) == (`GPIO_BASE >> 12);
    idx         = addr[9:2];
    e.write     = write;
    e.addr      = addr;
    e.data      = write ? random_bits(`SOC_DATA_W) : '0;
    e.exp_err   = !(in_iram || in_dram || in_gpio);
    e.exp_rdata = '0;
    if (in_iram)
    begin
      if (write)
        iram_model[idx] = e.data;
      e.exp_rdata = iram_model[idx];
    end
    else if (in_dram)
    begin
      if (write)
        dram_model[idx] = e.data;
      e.exp_rdata = dram_model[idx];
    end
    else if (in_gpio && addr[11:2] == 10'd0)
    begin
      if (write)
        gpio_model = e.data[`GPIO_W-1:0];
      e.exp_rdata[`GPIO_W-1:0] = gpio_model;
    end
    else if (in_gpio && addr[11:2] == 10'd1)
      e.exp_rdata[`GPIO_W-1:0] = gpio_in_value;
    stim[num_entries] = e;
    num_entries++;
  endtask

  task automatic build_stimulus();
    lfsr_state    = 32'h7690670e;
    num_entries   = 0;
    gpio_model    = '0;
    gpio_in_value = random_bits(`GPIO_W);
    add_entry(1'b0, `GPIO_BASE);
    // same word indices in both rams
    add_entry(1'b1, `IRAM_BASE + 32'h000);
    add_entry(1'b1, `IRAM_BASE + 32'h004);
    add_entry(1'b1, `IRAM_BASE + 32'h3FC);
    add_entry(1'b1, `DRAM_BASE + 32'h000);
    add_entry(1'b1, `DRAM_BASE + 32'h004);
    add_entry(1'b1, `DRAM_BASE + 32'h3FC);
    add_entry(1'b0, `IRAM_BASE + 32'h000);
    add_entry(1'b0, `DRAM_BASE + 32'h000);
    add_entry(1'b0, `IRAM_BASE + 32'h004);
    add_entry(1'b0, `DRAM_BASE + 32'h004);
    add_entry(1'b0, `IRAM_BASE + 32'h3FC);
    add_entry(1'b0, `DRAM_BASE + 32'h3FC);
    // gpio output, input read-back, read-only and empty words
    add_entry(1'b1, `GPIO_BASE);
    add_entry(1'b0, `GPIO_BASE);
    add_entry(1'b0, `GPIO_BASE + 32'h4);
    add_entry(1'b1, `GPIO_BASE + 32'h4);
    add_entry(1'b0, `GPIO_BASE + 32'h4);
    add_entry(1'b0, `GPIO_BASE + 32'h8);
    add_entry(1'b0, `GPIO_BASE);
    // unmapped accesses must leave everything alone
    add_entry(1'b1, 32'h3000_0000);
    add_entry(1'b0, `IRAM_BASE + 32'h000);
    add_entry(1'b0, `DRAM_BASE + 32'h000);
    add_entry(1'b0, 32'h4000_0010);
    add_entry(1'b0, `GPIO_BASE);
    // read right after write
    add_entry(1'b1, `DRAM_BASE + 32'h010);
    add_entry(1'b0, `DRAM_BASE + 32'h010);
    add_entry(1'b1, `IRAM_BASE + 32'h020);
    add_entry(1'b0, `IRAM_BASE + 32'h020);
    add_entry(1'b1, `GPIO_BASE);
    add_entry(1'b0, `GPIO_BASE);
  endtask

  initial
  begin
    int limit;
    wait (stim_ready === 1'b1);
    limit = num_entries * 4 + RESET_CYCLES + 4;
    repeat (limit) @(posedge clk);
    $display("timeout: the transfers did not finish within %0d clock cycles", limit);
    stop_with_failure();
  end

  initial
  begin
    entry_t cur;
    int     low_cycles;
    reset_n    = 1'b0;
    haddr_i    = '0;
    htrans_i   = IDLE;
    hwrite_i   = 1'b0;
    hwdata_i   = '0;
    gpio_i     = '0;
    stim_ready = 1'b0;
    build_stimulus();
    stim_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    gpio_i  <= gpio_in_value;
    @(negedge clk);
    check_ready(hready_o, 1'b1, "after reset");
    check_resp(hresp_o, 1'b0, "after reset");

    @(posedge clk);
    haddr_i  <= stim[0].addr;
    hwrite_i <= stim[0].write;
    htrans_i <= NONSEQ;

    for (int k = 0; k < num_entries; k++)
    begin
      cur = stim[k];
      // acceptance edge, the next address goes out during this data phase
      @(posedge clk);
      hwdata_i <= cur.data;
      if (k + 1 < num_entries)
      begin
        haddr_i  <= stim[k + 1].addr;
        hwrite_i <= stim[k + 1].write;
        htrans_i <= NONSEQ;
      end
      else
        htrans_i <= IDLE;

      @(negedge clk);
      low_cycles = 0;
      while (hready_o !== 1'b1)
      begin
        check_resp(hresp_o, cur.exp_err, $sformatf("entry %0d first data cycle", k));
        low_cycles++;
        @(negedge clk);
      end
      if (low_cycles != 1)
        report_mismatch($sformatf("entry %0d: hready low for %0d cycles, expected 1",
                                  k, low_cycles));
      check_resp(hresp_o, cur.exp_err, $sformatf("entry %0d last data cycle", k));
      if (!cur.write && !cur.exp_err)
        check_data(hrdata_o, cur.exp_rdata, $sformatf("entry %0d read %h", k, cur.addr));
      if (cur.write && cur.addr == `GPIO_BASE)
        check_gpio(gpio_o, cur.data[`GPIO_W-1:0], $sformatf("entry %0d gpio write", k));
    end

    $display("Test OK");
    $finish;
  end

endmodule

/* hw/soc_fabric_top.sv */
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_fabric_top (
  input  logic               clk,
  input  logic               reset_n,
  input  soc_pkg::haddr_t    haddr_i,
  input  soc_pkg::htrans_e   htrans_i,
  input  logic               hwrite_i,
  input  soc_pkg::hdata_t    hwdata_i,
  output soc_pkg::hdata_t    hrdata_o,
  output logic               hready_o,
  output logic               hresp_o,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o
);
  import soc_pkg::*;

  logic      dec_ready;
  logic      rsp_ready;
  logic      resp_valid;
  bus_resp_t resp;

  bus_req_if req_if ();

  addr_decode_stage decode_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hready_o (dec_ready),
    .req      (req_if.decoder)
  );

  slave_access_stage access_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req_if.access),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  // early error flag comes from the access stage decode of the held request
  response_stage response_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .resp_valid_i (resp_valid),
    .resp_i       (resp),
    .req_valid_i  (req_if.valid),
    .req_err_i    (resp.err),
    .hready_o     (rsp_ready),
    .hresp_o      (hresp_o),
    .hrdata_o     (hrdata_o)
  );

  assign hready_o = dec_ready & rsp_ready;

endmodule

/* hw/response_stage.sv */
`timescale 1ns/1ps

module response_stage (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               resp_valid_i,
  input  soc_pkg::bus_resp_t resp_i,
  input  logic               req_valid_i,
  input  logic               req_err_i,
  output logic               hready_o,
  output logic               hresp_o,
  output soc_pkg::hdata_t    hrdata_o
);
  import soc_pkg::*;

  logic      held_valid;
  bus_resp_t held;

  // response lives for one cycle, it clears itself
  pipe_reg #(
    .payload_t (bus_resp_t)
  ) resp_reg (
    .clk     (clk),
    .reset_n (reset_n),
    .load_i  (resp_valid_i),
    .clear_i (held_valid),
    .data_i  (resp_i),
    .valid_o (held_valid),
    .data_o  (held)
  );

  // not ready until the response has been captured
  assign hready_o = ~resp_valid_i;

  // error is two cycles, the first comes straight from the open request
  assign hresp_o = (req_valid_i & req_err_i) | (held_valid & held.err);

  assign hrdata_o = held.rdata;

endmodule

/* hw/slave_access_stage.sv */
`timescale 1ns/1ps
`include "soc_params.svh"

module slave_access_stage (
  input  logic               clk,
  input  logic               reset_n,
  bus_req_if.access          req,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic               resp_valid_o,
  output soc_pkg::bus_resp_t resp_o
);
  import soc_pkg::*;

  logic   iram_en;
  logic   dram_en;
  logic   gpio_en;
  hdata_t iram_rdata;
  hdata_t dram_rdata;
  hdata_t gpio_rdata;

  // only the selected target sees the access, unmapped selects none
  assign iram_en = req.valid && (req.req.target == TGT_IRAM);
  assign dram_en = req.valid && (req.req.target == TGT_DRAM);
  assign gpio_en = req.valid && (req.req.target == TGT_GPIO);

  sram_word #(
    .DEPTH (`IRAM_WORDS)
  ) iram_inst (
    .clk     (clk),
    .en_i    (iram_en),
    .we_i    (req.req.write),
    .index_i (req.req.index),
    .wdata_i (req.wdata),
    .rdata_o (iram_rdata)
  );

  sram_word #(
    .DEPTH (`DRAM_WORDS)
  ) dram_inst (
    .clk     (clk),
    .en_i    (dram_en),
    .we_i    (req.req.write),
    .index_i (req.req.index),
    .wdata_i (req.wdata),
    .rdata_o (dram_rdata)
  );

  gpio_regs gpio_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .en_i    (gpio_en),
    .we_i    (req.req.write),
    .index_i (req.req.index),
    .wdata_i (req.wdata),
    .gpio_i  (gpio_i),
    .rdata_o (gpio_rdata),
    .gpio_o  (gpio_o)
  );

  // read data mux and error flag
  always_comb
  begin
    resp_o.rdata = '0;
    resp_o.err   = 1'b0;
    case (req.req.target)
      TGT_IRAM: resp_o.rdata = iram_rdata;
      TGT_DRAM: resp_o.rdata = dram_rdata;
      TGT_GPIO: resp_o.rdata = gpio_rdata;
      default:  resp_o.err   = 1'b1;
    endcase
  end

  // access completes on the edge ending the first data cycle
  assign req.done     = req.valid;
  assign resp_valid_o = req.valid;

endmodule

/* hw/gpio_regs.sv */
`timescale 1ns/1ps
`include "soc_params.svh"

module gpio_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               en_i,
  input  logic               we_i,
  input  soc_pkg::haddr_t    index_i,
  input  soc_pkg::hdata_t    wdata_i,
  input  logic [`GPIO_W-1:0] gpio_i,
  output soc_pkg::hdata_t    rdata_o,
  output logic [`GPIO_W-1:0] gpio_o
);
  import soc_pkg::*;

  // word 0 is the output register, word 1 is read only
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      gpio_o <= '0;
    else if (en_i && we_i && index_i == haddr_t'(0))
      gpio_o <= wdata_i[`GPIO_W-1:0];
  end

  always_comb
  begin
    rdata_o = '0;
    if (index_i == haddr_t'(0))
      rdata_o[`GPIO_W-1:0] = gpio_o;
    else if (index_i == haddr_t'(1))
      rdata_o[`GPIO_W-1:0] = gpio_i;
  end

endmodule

/* hw/sram_word.sv */
`timescale 1ns/1ps

module sram_word #(
  parameter int unsigned DEPTH = 256
) (
  input  logic            clk,
  input  logic            en_i,
  input  logic            we_i,
  input  soc_pkg::haddr_t index_i,
  input  soc_pkg::hdata_t wdata_i,
  output soc_pkg::hdata_t rdata_o
);
  import soc_pkg::*;

  localparam int unsigned AW = $clog2(DEPTH);

  hdata_t        mem [DEPTH];
  logic [AW-1:0] addr;

  // upper index bits are ignored, so the window wraps
  assign addr = index_i[AW-1:0];

  always_ff @(posedge clk)
  begin
    if (en_i && we_i)
      mem[addr] <= wdata_i;
  end

  // read data is captured by the response register on the access edge
  assign rdata_o = mem[addr];

endmodule

/* hw/addr_decode_stage.sv */
`timescale 1ns/1ps
`include "soc_params.svh"

module addr_decode_stage (
  input  logic             clk,
  input  logic             reset_n,
  input  soc_pkg::haddr_t  haddr_i,
  input  soc_pkg::htrans_e htrans_i,
  input  logic             hwrite_i,
  input  soc_pkg::hdata_t  hwdata_i,
  output logic             hready_o,
  bus_req_if.decoder       req
);
  import soc_pkg::*;

  logic     accept;
  bus_req_t req_d;

  // base and mask compare per window, word offset inside the window
  always_comb
  begin
    req_d.write = hwrite_i;
    if ((haddr_i & `IRAM_MASK) == `IRAM_BASE)
    begin
      req_d.target = TGT_IRAM;
      req_d.index  = (haddr_i & ~`IRAM_MASK) >> 2;
    end
    else if ((haddr_i & `DRAM_MASK) == `DRAM_BASE)
    begin
      req_d.target = TGT_DRAM;
      req_d.index  = (haddr_i & ~`DRAM_MASK) >> 2;
    end
    else if ((haddr_i & `GPIO_MASK) == `GPIO_BASE)
    begin
      req_d.target = TGT_GPIO;
      req_d.index  = (haddr_i & ~`GPIO_MASK) >> 2;
    end
    else
    begin
      req_d.target = TGT_NONE;
      req_d.index  = '0;
    end
  end

  // stall the master while a data phase is open
  assign hready_o = ~req.valid;

  // busy counts as idle
  assign accept = hready_o && (htrans_i == NONSEQ || htrans_i == SEQ);

  // write data arrives in the data phase, next to the held request
  assign req.wdata = hwdata_i;

  pipe_reg #(
    .payload_t (bus_req_t)
  ) req_reg (
    .clk     (clk),
    .reset_n (reset_n),
    .load_i  (accept),
    .clear_i (req.done),
    .data_i  (req_d),
    .valid_o (req.valid),
    .data_o  (req.req)
  );

endmodule

/* hw/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     load_i,
  input  logic     clear_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // load wins over clear so a new item can follow directly
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      valid_o <= 1'b0;
    else if (load_i)
      valid_o <= 1'b1;
    else if (clear_i)
      valid_o <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
      data_o <= data_i;
  end

endmodule

/* hw/bus_req_if.sv */
`timescale 1ns/1ps

interface bus_req_if;
  import soc_pkg::*;

  logic     valid;
  bus_req_t req;
  hdata_t   wdata;
  logic     done;

  modport decoder (
    output valid,
    output req,
    output wdata,
    input  done
  );

  modport access (
    input  valid,
    input  req,
    input  wdata,
    output done
  );

endinterface

/* hw/soc_pkg.sv */
`include "soc_params.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] haddr_t;
  typedef logic [`SOC_DATA_W-1:0] hdata_t;

  // ahb-lite transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // decoded slave
  typedef enum logic [1:0] {
    TGT_IRAM = 2'd0,
    TGT_DRAM = 2'd1,
    TGT_GPIO = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

  // request held during the data phase, index is a word offset in the window
  typedef struct packed {
    target_e target;
    logic    write;
    haddr_t  index;
  } bus_req_t;

  typedef struct packed {
    hdata_t rdata;
    logic   err;
  } bus_resp_t;

endpackage

/* hw/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// address map, each window is 4 KB
`define IRAM_BASE 32'h0000_0000
`define IRAM_MASK 32'hFFFF_F000

`define DRAM_BASE 32'h1000_0000
`define DRAM_MASK 32'hFFFF_F000

`define GPIO_BASE 32'h2000_0000
`define GPIO_MASK 32'hFFFF_F000

// memory depths in words, higher indices wrap
`define IRAM_WORDS 256
`define DRAM_WORDS 256

// gpio port width
`define GPIO_W 8

`endif
